/* snake_geom_pkg.sv */
`default_nettype none

package snake_geom_pkg;

	////////////////////////////////////////////////////////////
	// Playfield geometry
	////////////////////////////////////////////////////////////

	// Grid of 32 by 32 cells
	localparam int unsigned GRID_W = 32;
	localparam int unsigned GRID_H = 32;

	// Coordinate widths follow the grid size
	localparam int unsigned X_BITS = $clog2(GRID_W);
	localparam int unsigned Y_BITS = $clog2(GRID_H);

	typedef logic [X_BITS-1:0] coord_x_t;
	typedef logic [Y_BITS-1:0] coord_y_t;

	// Last valid cell on each axis, used by the wall check
	localparam coord_x_t X_MAX = coord_x_t'(GRID_W - 1);
	localparam coord_y_t Y_MAX = coord_y_t'(GRID_H - 1);

	// Heading; up increments y
	typedef enum logic [1:0] {
		DIR_RIGHT = 2'd0,
		DIR_UP    = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_DOWN  = 2'd3
	} dir_t;

	// One body segment, x in the top bits and the valid flag at bit 0
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		logic     active;
	} seg_t;

	// Head position after a start
	localparam coord_x_t START_X = coord_x_t'(GRID_W / 2);
	localparam coord_y_t START_Y = coord_y_t'(GRID_H / 2);
	localparam seg_t START_SEG = '{x: START_X, y: START_Y, active: 1'b1};

	// Empty slot
	localparam seg_t SEG_NONE = '0;

endpackage

`default_nettype wire

/* snake_game_pkg.sv */
`default_nettype none

package snake_game_pkg;

	////////////////////////////////////////////////////////////
	// Body storage and timing
	////////////////////////////////////////////////////////////

	// Segment memory depth and slot address width
	localparam int unsigned MAX_LEN = 64;
	localparam int unsigned ADDR_BITS = $clog2(MAX_LEN);

	// Length runs 1 to MAX_LEN, so one bit above the address
	typedef logic [ADDR_BITS:0] len_t;
	typedef logic [7:0] score_t;

	localparam len_t LEN_ONE = len_t'(1);
	localparam len_t LEN_MAX = len_t'(MAX_LEN);

	// Move interval and walk duration
	localparam int unsigned TICK_CYCLES = 200;
	localparam int unsigned WALK_CYCLES = MAX_LEN + 2;

	typedef logic [$clog2(TICK_CYCLES)-1:0] tick_t;
	typedef logic [$clog2(WALK_CYCLES)-1:0] walk_cnt_t;

	localparam tick_t TICK_LAST = tick_t'(TICK_CYCLES - 1);

	// Read and write offsets of the walk relative to the step cycle
	localparam walk_cnt_t RD_LAG = walk_cnt_t'(1);
	localparam walk_cnt_t WR_LAG = walk_cnt_t'(2);
	localparam walk_cnt_t WALK_LAST = walk_cnt_t'(WALK_CYCLES - 1);

	// Food LFSR start value
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	////////////////////////////////////////////////////////////
	// Block-to-block words
	////////////////////////////////////////////////////////////

	// Controller to body
	typedef struct packed {
		snake_geom_pkg::seg_t head;
		logic                 grow;
	} step_req_t;

	// Body back to controller
	typedef struct packed {
		logic busy;
		logic self_col;
		len_t length;
	} body_status_t;

	// Game state seen from outside
	typedef struct packed {
		logic                 running;
		logic                 game_over;
		logic                 wall_col;
		logic                 self_col;
		score_t               score;
		len_t                 length;
		snake_geom_pkg::seg_t head;
	} game_status_t;

endpackage

`default_nettype wire

/* segment_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module segment_ram (
	input  logic                                clk,
	input  logic                                we,
	input  logic [snake_game_pkg::ADDR_BITS-1:0] waddr,
	input  snake_geom_pkg::seg_t                wdata,
	input  logic [snake_game_pkg::ADDR_BITS-1:0] raddr,
	output snake_geom_pkg::seg_t                rdata
);
	import snake_geom_pkg::*;
	import snake_game_pkg::*;

	// One slot per body segment
	seg_t mem [MAX_LEN];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, one cycle of latency
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* snake_body.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_body (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 step,
	input  snake_game_pkg::step_req_t            req,
	input  logic                                 restart,
	output logic                                 mem_we,
	output logic [snake_game_pkg::ADDR_BITS-1:0] mem_waddr,
	output snake_geom_pkg::seg_t                 mem_wdata,
	output logic [snake_game_pkg::ADDR_BITS-1:0] mem_raddr,
	input  snake_geom_pkg::seg_t                 mem_rdata,
	output snake_game_pkg::body_status_t         bstat,
	output logic                                 done
);
	import snake_geom_pkg::*;
	import snake_game_pkg::*;

	// Walk control
	logic      busy;
	walk_cnt_t cnt;
	walk_cnt_t rd_idx;
	walk_cnt_t wr_idx;

	// Request captured at the step
	seg_t      head_q;
	logic      restart_q;
	len_t      new_len;
	len_t      next_len;

	// Body state
	len_t      length;
	logic      self_col;

	// Copy pipeline
	seg_t      hold;
	logic      in_new;
	logic      kept;
	logic      col_hit;

	////////////////////////////////////////////////////////////
	// Length of the body after this move
	////////////////////////////////////////////////////////////

	always_comb begin
		if (restart) begin
			next_len = LEN_ONE;
		end else if (req.grow && (length != LEN_MAX)) begin
			next_len = length + 1'b1;
		end else begin
			next_len = length;
		end
	end

	////////////////////////////////////////////////////////////
	// Walk addressing
	////////////////////////////////////////////////////////////

	// Slot read at cycle i+1, rewritten at cycle i+2
	assign rd_idx = cnt - RD_LAG;
	assign wr_idx = cnt - WR_LAG;

	assign mem_raddr = rd_idx[ADDR_BITS-1:0];
	assign mem_waddr = wr_idx[ADDR_BITS-1:0];
	assign mem_we    = busy && (cnt >= WR_LAG);

	// Slot lies inside the new body
	assign in_new = wr_idx < new_len;
	// Old slot on the read port survives this move
	assign kept   = (wr_idx + 1'b1) < new_len;

	// Head into slot 0, old slot i-1 into slot i, blanks past the tail
	always_comb begin
		if (wr_idx == '0) begin
			mem_wdata = head_q;
		end else if (in_new) begin
			mem_wdata = hold;
		end else begin
			mem_wdata = SEG_NONE;
		end
	end

	// Read port shows old slot wr_idx in the same cycle
	assign col_hit = mem_we && !restart_q && kept && mem_rdata.active &&
		(mem_rdata.x == head_q.x) && (mem_rdata.y == head_q.y);

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			cnt      <= '0;
			self_col <= 1'b0;
			length   <= LEN_ONE;
		end else begin
			done <= 1'b0;
			if (busy) begin
				cnt <= cnt + 1'b1;
				if (col_hit) begin
					self_col <= 1'b1;
				end
				// Last write goes out this cycle
				if (cnt == WALK_LAST) begin
					busy   <= 1'b0;
					done   <= 1'b1;
					length <= new_len;
				end
			end else if (step) begin
				busy     <= 1'b1;
				cnt      <= RD_LAG;
				self_col <= 1'b0;
			end
		end
	end

	// Step payload and the one-slot delay of the copy
	always_ff @(posedge clk) begin
		hold <= mem_rdata;
		if (step && !busy) begin
			head_q    <= req.head;
			restart_q <= restart;
			new_len   <= next_len;
		end
	end

	assign bstat = '{busy: busy, self_col: self_col, length: length};

endmodule

`default_nettype wire

/* food_placer.sv */
`timescale 1ns/1ps
`default_nettype none

module food_placer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 place,
	output snake_geom_pkg::seg_t food
);
	import snake_geom_pkg::*;
	import snake_game_pkg::*;

	logic [15:0] lfsr;
	logic        fb;
	// High for the first cycle out of reset
	logic        first;

	// Taps 16, 14, 13, 11
	assign fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr  <= LFSR_SEED;
			first <= 1'b1;
		end else begin
			first <= 1'b0;
			// New bit enters at the bottom
			if (first || place) begin
				lfsr <= {lfsr[14:0], fb};
			end
		end
	end

	// Low ten bits give the cell
	assign food = '{
		x:      lfsr[X_BITS-1:0],
		y:      lfsr[X_BITS+Y_BITS-1:X_BITS],
		active: 1'b1
	};

endmodule

`default_nettype wire

/* game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module game_ctrl (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic                         move_enable,
	input  snake_geom_pkg::dir_t         move,
	input  snake_geom_pkg::seg_t         food,
	input  snake_game_pkg::body_status_t bstat,
	input  logic                         done,
	output logic                         step,
	output logic                         restart,
	output logic                         place,
	output snake_game_pkg::step_req_t    req,
	output snake_game_pkg::game_status_t status
);
	import snake_geom_pkg::*;
	import snake_game_pkg::*;

	dir_t   dir;
	seg_t   head;
	seg_t   next_head;
	logic   at_wall;
	logic   eat;

	// Game flags and score
	logic   running;
	logic   game_over;
	logic   wall_col;
	logic   self_col;
	score_t score;

	// Move sequencing
	logic   in_walk;
	logic   start_pend;
	tick_t  tick;
	logic   tick_hit;
	logic   issue_restart;
	logic   issue_move;
	logic   wall_hit;

	// Latch heading, a reversal is dropped
	always_ff @(posedge clk) begin
		if (reset || start) begin
			dir <= DIR_RIGHT;
		end else if (move_enable && (move != dir_t'(dir ^ 2'b10))) begin
			dir <= move;
		end
	end

	////////////////////////////////////////////////////////////
	// Next head, wall and food checks
	////////////////////////////////////////////////////////////

	always_comb begin
		next_head = head;
		at_wall   = 1'b0;
		case (dir)
			DIR_RIGHT: begin
				next_head.x = head.x + 1'b1;
				at_wall     = (head.x == X_MAX);
			end
			DIR_UP: begin
				next_head.y = head.y + 1'b1;
				at_wall     = (head.y == Y_MAX);
			end
			DIR_LEFT: begin
				next_head.x = head.x - 1'b1;
				at_wall     = (head.x == '0);
			end
			default: begin
				next_head.y = head.y - 1'b1;
				at_wall     = (head.y == '0);
			end
		endcase
	end

	assign eat = food.active && (next_head.x == food.x) && (next_head.y == food.y);

	// Tick expires only between walks
	assign tick_hit = running && !in_walk && !start_pend && !bstat.busy &&
		(tick == TICK_LAST);

	assign issue_restart = start_pend && !start && !in_walk && !bstat.busy;
	assign issue_move    = tick_hit && !start && !at_wall;
	assign wall_hit      = tick_hit && !start && at_wall;

	////////////////////////////////////////////////////////////
	// Game state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			running    <= 1'b0;
			game_over  <= 1'b0;
			wall_col   <= 1'b0;
			self_col   <= 1'b0;
			score      <= '0;
			head       <= START_SEG;
			in_walk    <= 1'b0;
			start_pend <= 1'b0;
			tick       <= '0;
			step       <= 1'b0;
			restart    <= 1'b0;
			place      <= 1'b0;
		end else begin
			step    <= 1'b0;
			restart <= 1'b0;
			place   <= 1'b0;
			// Timer restarts when the walk ends
			if (done) begin
				in_walk <= 1'b0;
				tick    <= '0;
			end
			if (start) begin
				running    <= 1'b1;
				game_over  <= 1'b0;
				wall_col   <= 1'b0;
				self_col   <= 1'b0;
				score      <= '0;
				head       <= START_SEG;
				tick       <= '0;
				start_pend <= 1'b1;
			end else if (start_pend) begin
				// Clearing walk once the body is free
				if (issue_restart) begin
					step       <= 1'b1;
					restart    <= 1'b1;
					in_walk    <= 1'b1;
					start_pend <= 1'b0;
				end
			end else if (done) begin
				head <= req.head;
				if (bstat.self_col) begin
					self_col  <= 1'b1;
					game_over <= 1'b1;
					running   <= 1'b0;
				end
			end else if (wall_hit) begin
				wall_col  <= 1'b1;
				game_over <= 1'b1;
				running   <= 1'b0;
			end else if (issue_move) begin
				step    <= 1'b1;
				in_walk <= 1'b1;
				// Eat, new food and score in the step cycle
				if (eat) begin
					place <= 1'b1;
					score <= score + 1'b1;
				end
			end else if (running && !in_walk) begin
				tick <= tick + 1'b1;
			end
		end
	end

	// Request word for the body
	always_ff @(posedge clk) begin
		if (issue_restart) begin
			req <= '{head: START_SEG, grow: 1'b0};
		end else if (issue_move) begin
			req <= '{head: next_head, grow: eat};
		end
	end

	assign status = '{
		running:   running,
		game_over: game_over,
		wall_col:  wall_col,
		self_col:  self_col,
		score:     score,
		length:    bstat.length,
		head:      head
	};

endmodule

`default_nettype wire

/* snake_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_game_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 start,
	input  logic                                 move_enable,
	input  snake_geom_pkg::dir_t                 move,
	input  logic [snake_game_pkg::ADDR_BITS-1:0] seg_index,
	output snake_game_pkg::game_status_t         status,
	output snake_geom_pkg::seg_t                 food,
	output snake_geom_pkg::seg_t                 seg_rd,
	output logic                                 step_done
);
	import snake_geom_pkg::*;
	import snake_game_pkg::*;

	// Controller to body and placer
	logic                 step;
	logic                 restart;
	logic                 place;
	logic                 done;
	step_req_t            req;
	body_status_t         bstat;

	// Memory ports
	logic                 mem_we;
	logic [ADDR_BITS-1:0] mem_waddr;
	seg_t                 mem_wdata;
	logic [ADDR_BITS-1:0] body_raddr;
	logic [ADDR_BITS-1:0] ram_raddr;
	seg_t                 mem_rdata;

	// Walk owns the read port while busy
	assign ram_raddr = bstat.busy ? body_raddr : seg_index;
	assign seg_rd    = mem_rdata;
	assign step_done = done;

	game_ctrl u_game_ctrl (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.move_enable(move_enable),
		.move       (move),
		.food       (food),
		.bstat      (bstat),
		.done       (done),
		.step       (step),
		.restart    (restart),
		.place      (place),
		.req        (req),
		.status     (status)
	);

	snake_body u_snake_body (
		.clk      (clk),
		.reset    (reset),
		.step     (step),
		.req      (req),
		.restart  (restart),
		.mem_we   (mem_we),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.mem_raddr(body_raddr),
		.mem_rdata(mem_rdata),
		.bstat    (bstat),
		.done     (done)
	);

	segment_ram u_segment_ram (
		.clk  (clk),
		.we   (mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.raddr(ram_raddr),
		.rdata(mem_rdata)
	);

	food_placer u_food_placer (
		.clk  (clk),
		.reset(reset),
		.place(place),
		.food (food)
	);

endmodule

`default_nettype wire

/* tb_snake_tasks.svh */
	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// One-cycle heading strobe, reversal dropped in the model too
	task automatic strobe_dir(input dir_t d);
		@(negedge clk);
		move_enable = 1'b1;
		move        = d;
		@(negedge clk);
		move_enable = 1'b0;
		if (d != opposite(m_dir)) begin
			m_dir = d;
		end
	endtask

	// Bounded wait for the end of a walk
	task automatic wait_step_done(input string what);
		int n;
		n = 0;
		while ((step_done !== 1'b1) && (n < WAIT_LIMIT)) begin
			@(negedge clk);
			n++;
		end
		if (step_done !== 1'b1) begin
			timeouts++;
			$display("Timeout: no step_done after %s", what);
		end
		// Head register follows one cycle after done
		@(negedge clk);
	endtask

	// Let the next tick happen with the heading already latched
	task automatic advance();
		logic hit_wall;
		int   n;
		int   pulses;
		logic seen;
		if (m_over) begin
			return;
		end
		model_move(hit_wall);
		if (hit_wall) begin
			n      = 0;
			pulses = 0;
			seen   = 1'b0;
			// Whole window, a missing walk is the expected outcome
			while (n < WAIT_LIMIT) begin
				@(negedge clk);
				n++;
				if (step_done === 1'b1) begin
					pulses++;
				end
				if (status.game_over === 1'b1) begin
					seen = 1'b1;
				end
			end
			if (!seen) begin
				timeouts++;
				$display("Timeout: game over never raised after running into a wall");
			end
			if (pulses != 0) begin
				errors++;
				$display("Error: a step_done arrived after the wall hit");
			end
		end else begin
			wait_step_done("a move");
		end
		check_status();
	endtask

	task automatic do_move(input dir_t d);
		if (m_over) begin
			return;
		end
		strobe_dir(d);
		advance();
	endtask

	// Slot reads, one cycle of latency each
	task automatic check_body(input int slots);
		seg_t got;
		int   i;
		for (i = 0; i < slots; i++) begin
			@(negedge clk);
			seg_index = i[ADDR_BITS-1:0];
			@(negedge clk);
			got = seg_rd;
			if (i < m_len) begin
				check_seg($sformatf("seg_rd slot %0d", i), m_body[i], got);
			end else begin
				check_flag($sformatf("seg_rd slot %0d active", i), 1'b0, got.active);
			end
		end
	endtask

	task automatic start_game();
		int i;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		for (i = 0; i < MAX_LEN; i++) begin
			m_body[i] = '0;
		end
		m_body[0]  = '{x: START_X, y: START_Y, active: 1'b1};
		m_len      = 1;
		m_score    = 0;
		m_dir      = DIR_RIGHT;
		m_running  = 1'b1;
		m_over     = 1'b0;
		m_wall     = 1'b0;
		m_self     = 1'b0;
		// Clearing walk ends with its own done
		wait_step_done("start");
		check_status();
	endtask

	// Heading toward a cell, x first, turning aside on a reversal
	function automatic dir_t toward(input seg_t h, input seg_t t, input dir_t cur);
		dir_t want;
		logic horiz;
		horiz = (cur == DIR_RIGHT) || (cur == DIR_LEFT);
		if (h.x != t.x) begin
			want = (t.x > h.x) ? DIR_RIGHT : DIR_LEFT;
		end else if (h.y != t.y) begin
			want = (t.y > h.y) ? DIR_UP : DIR_DOWN;
		end else begin
			want = opposite(cur);
		end
		if (want == opposite(cur)) begin
			if (horiz) begin
				want = (h.y < Y_MAX) ? DIR_UP : DIR_DOWN;
			end else begin
				want = (h.x < X_MAX) ? DIR_RIGHT : DIR_LEFT;
			end
		end
		return want;
	endfunction

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_start();
		repeat (2) @(negedge clk);
		// Placer steps once out of reset
		m_lfsr = food_lfsr_next(m_lfsr);
		check_flag("status.running", 1'b0, status.running);
		check_flag("status.game_over", 1'b0, status.game_over);
		check_seg("food", food_cell(m_lfsr), food);
		start_game();
		check_body(MAX_LEN);
	endtask

	task automatic test_movement();
		int k;
		strobe_dir(DIR_RIGHT);
		// Reversal, must be ignored
		strobe_dir(DIR_LEFT);
		for (k = 0; k < 4; k++) begin
			advance();
		end
		check_body(1);
	endtask

	task automatic test_eating();
		score_t s0;
		len_t   l0;
		int     k;
		s0 = m_score;
		l0 = m_len;
		k  = 0;
		while (!m_over && (m_score == s0) && (k < 80)) begin
			do_move(toward(m_body[0], food_cell(m_lfsr), m_dir));
			k++;
		end
		check_score("score after eat", s0 + 1'b1, status.score);
		check_len("length after eat", l0 + 1'b1, status.length);
		check_body(m_len);
	endtask

	task automatic test_wall();
		int k;
		start_game();
		k = 0;
		while (!m_over && (k < 40)) begin
			do_move(DIR_RIGHT);
			k++;
		end
		check_flag("wall_col at edge", 1'b1, status.wall_col);
		check_flag("running at edge", 1'b0, status.running);
	endtask

	task automatic test_self_collision();
		seg_t spot;
		int   k;
		start_game();
		k = 0;
		while (!m_over && (m_len < 5) && (k < 400)) begin
			do_move(toward(m_body[0], food_cell(m_lfsr), m_dir));
			k++;
		end
		// Room on every side before the turns
		spot = '{x: 10, y: 10, active: 1'b1};
		k    = 0;
		while (!m_over && (m_body[0] != spot) && (k < 80)) begin
			do_move(toward(m_body[0], spot, m_dir));
			k++;
		end
		if (m_dir == DIR_LEFT) begin
			do_move(DIR_UP);
		end
		// Neck straight behind the head, then a tight loop
		do_move(DIR_RIGHT);
		do_move(DIR_UP);
		do_move(DIR_LEFT);
		do_move(DIR_DOWN);
		check_flag("self_col after loop", 1'b1, status.self_col);
		check_flag("game_over after loop", 1'b1, status.game_over);
		check_body(m_len);
	endtask

	task automatic test_random_run();
		logic [1:0] r;
		dir_t       d;
		int         k;
		start_game();
		for (k = 0; (k < 30) && !m_over; k++) begin
			// Two LFSR steps per heading
			rng  = rng_next(rng);
			r[0] = rng[0];
			rng  = rng_next(rng);
			r[1] = rng[0];
			d    = dir_t'(r);
			if (d == opposite(m_dir)) begin
				d = m_dir;
			end
			do_move(d);
		end
	endtask

/* tb_snake_game.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_snake_game;
	import snake_geom_pkg::*;
	import snake_game_pkg::*;

	// Longest wait for a move or a status change
	localparam int WAIT_LIMIT = TICK_CYCLES + WALK_CYCLES + 20;

	logic                 clk;
	logic                 reset;
	logic                 start;
	logic                 move_enable;
	dir_t                 move;
	logic [ADDR_BITS-1:0] seg_index;
	game_status_t         status;
	seg_t                 food;
	seg_t                 seg_rd;
	logic                 step_done;

	int errors;
	int timeouts;

	////////////////////////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////////////////////////

	// Slot 0 is the head
	seg_t        m_body [MAX_LEN];
	len_t        m_len;
	score_t      m_score;
	dir_t        m_dir;
	logic [15:0] m_lfsr;
	logic        m_running;
	logic        m_over;
	logic        m_wall;
	logic        m_self;
	// Direction source for the random run
	logic [31:0] rng;

	snake_game_top u_snake_game_top (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.move_enable(move_enable),
		.move       (move),
		.seg_index  (seg_index),
		.status     (status),
		.food       (food),
		.seg_rd     (seg_rd),
		.step_done  (step_done)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Food LFSR, taps 16 14 13 11, new bit at the bottom
	function automatic logic [15:0] food_lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// x from bits 4..0, y from bits 9..5
	function automatic seg_t food_cell(input logic [15:0] s);
		seg_t c;
		c.x      = s[4:0];
		c.y      = s[9:5];
		c.active = 1'b1;
		return c;
	endfunction

	// Stimulus LFSR, taps 32 22 2 1
	function automatic logic [31:0] rng_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic dir_t opposite(input dir_t d);
		case (d)
			DIR_RIGHT: return DIR_LEFT;
			DIR_UP:    return DIR_DOWN;
			DIR_LEFT:  return DIR_RIGHT;
			default:   return DIR_UP;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_seg(input string name, input seg_t exp, input seg_t act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %0t %s expected (%0d,%0d,%b) got (%0d,%0d,%b)", $time, name,
				exp.x, exp.y, exp.active, act.x, act.y, act.active);
		end
	endtask

	task automatic check_len(input string name, input len_t exp, input len_t act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_score(input string name, input score_t exp, input score_t act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// Whole status word and food against the model
	task automatic check_status();
		check_seg("status.head", m_body[0], status.head);
		check_len("status.length", m_len, status.length);
		check_score("status.score", m_score, status.score);
		check_flag("status.running", m_running, status.running);
		check_flag("status.game_over", m_over, status.game_over);
		check_flag("status.wall_col", m_wall, status.wall_col);
		check_flag("status.self_col", m_self, status.self_col);
		check_seg("food", food_cell(m_lfsr), food);
	endtask

	// One tick of the model with the latched heading
	task automatic model_move(output logic hit_wall);
		seg_t nh;
		seg_t fd;
		len_t nl;
		logic eat;
		int   i;
		nh       = m_body[0];
		fd       = food_cell(m_lfsr);
		hit_wall = 1'b0;
		case (m_dir)
			DIR_RIGHT: begin
				hit_wall = (nh.x == X_MAX);
				nh.x     = nh.x + 1'b1;
			end
			DIR_UP: begin
				hit_wall = (nh.y == Y_MAX);
				nh.y     = nh.y + 1'b1;
			end
			DIR_LEFT: begin
				hit_wall = (nh.x == '0);
				nh.x     = nh.x - 1'b1;
			end
			default: begin
				hit_wall = (nh.y == '0);
				nh.y     = nh.y - 1'b1;
			end
		endcase
		if (hit_wall) begin
			m_wall    = 1'b1;
			m_over    = 1'b1;
			m_running = 1'b0;
		end else begin
			eat = (nh.x == fd.x) && (nh.y == fd.y);
			nl  = m_len;
			if (eat && (m_len < MAX_LEN)) begin
				nl = m_len + 1'b1;
			end
			// Only segments that survive the move can be hit
			for (i = 0; i < nl - 1; i++) begin
				if (m_body[i].active && (m_body[i].x == nh.x) && (m_body[i].y == nh.y)) begin
					m_self = 1'b1;
				end
			end
			for (i = MAX_LEN - 1; i > 0; i--) begin
				m_body[i] = m_body[i-1];
			end
			m_body[0] = nh;
			m_len     = nl;
			if (eat) begin
				m_score = m_score + 1'b1;
				m_lfsr  = food_lfsr_next(m_lfsr);
			end
			if (m_self) begin
				m_over    = 1'b1;
				m_running = 1'b0;
			end
		end
	endtask

	`include "tb_snake_tasks.svh"

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		errors      = 0;
		timeouts    = 0;
		reset       = 1'b1;
		start       = 1'b0;
		move_enable = 1'b0;
		move        = DIR_RIGHT;
		seg_index   = '0;
		rng         = 32'hfd1b;
		m_lfsr      = LFSR_SEED;
		// Three cycles of reset
		repeat (3) @(negedge clk);
		reset = 1'b0;
		test_reset_start();
		test_movement();
		test_eating();
		test_wall();
		test_self_collision();
		test_random_run();
		$display("Closing: %0d mismatches, %0d timeouts", errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
snake_geom_pkg.sv
snake_game_pkg.sv
segment_ram.sv
snake_body.sv
food_placer.sv
game_ctrl.sv
snake_game_top.sv
tb_snake_game.sv

/* Bender.yml */
package:
  name: snake_game

sources:
  - files:
      - snake_geom_pkg.sv
      - snake_game_pkg.sv
      - segment_ram.sv
      - snake_body.sv
      - food_placer.sv
      - game_ctrl.sv
      - snake_game_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_snake_game.sv
